// ==== logic/md_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types of the M-extension multiply/divide unit
// imported by every RTL block and by the testbench
////////////////////////////////////////////////////////////////////////////

package md_pkg;

  // operand and result width, fixed by the ISA
  localparam int XLEN     = 32;
  // divider shift count, holds 0..XLEN
  localparam int LOG_XLEN = 6;

  // funct3 order, so op[2] marks the divide group
  typedef enum logic [2:0] {
    MUL    = 3'd0,
    MULH   = 3'd1,
    MULHSU = 3'd2,
    MULHU  = 3'd3,
    DIV    = 3'd4,
    DIVU   = 3'd5,
    REM    = 3'd6,
    REMU   = 3'd7
  } md_op_e;

  // request at the top level
  typedef struct packed {
    md_op_e            op;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
  } md_req_t;

  // divider request, divisor already normalized
  typedef struct packed {
    logic [XLEN-1:0]     op_a;
    logic [XLEN-1:0]     op_b;
    logic [LOG_XLEN-1:0] op_b_shift;
    logic                op_b_is_zero;
    // zero for unsigned operations
    logic                op_b_sign;
    logic                div_signed;
    logic                div_rem;
  } div_req_t;

  // multiplier request
  typedef struct packed {
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            a_signed;
    logic            b_signed;
    logic            high;
  } mul_req_t;

  typedef enum logic [1:0] {DIV_IDLE, DIV_DIVIDE, DIV_FINISH} div_state_e;
  typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_FINISH} mul_state_e;

endpackage

// ==== logic/md_op_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// splits one request into divider and multiplier operands, combinational
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module md_op_decode import md_pkg::*; (
  input  md_req_t  req,
  output div_req_t div_req,
  output mul_req_t mul_req,
  output logic     is_div
);

  logic                a_signed;
  logic                b_signed;
  logic                high;
  logic                div_signed;
  logic                div_rem;
  logic                b_neg;
  logic [XLEN-1:0]     lead_src;
  logic [LOG_XLEN-1:0] lead_cnt;
  logic [LOG_XLEN-1:0] shift;

  // operation classes
  always_comb begin
    is_div     = 1'b0;
    a_signed   = 1'b0;
    b_signed   = 1'b0;
    high       = 1'b0;
    div_signed = 1'b0;
    div_rem    = 1'b0;
    case (req.op)
      MUL: ;
      MULH: begin
        a_signed = 1'b1;
        b_signed = 1'b1;
        high     = 1'b1;
      end
      MULHSU: begin
        a_signed = 1'b1;
        high     = 1'b1;
      end
      MULHU: high = 1'b1;
      DIV: begin
        is_div     = 1'b1;
        div_signed = 1'b1;
      end
      DIVU: is_div = 1'b1;
      REM: begin
        is_div     = 1'b1;
        div_signed = 1'b1;
        div_rem    = 1'b1;
      end
      REMU: begin
        is_div  = 1'b1;
        div_rem = 1'b1;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // divisor normalization
  ////////////////////////////////////////////////////////////////////////////

  // sign only matters for signed divides
  assign b_neg    = div_signed & req.op_b[XLEN-1];
  // leading ones of a negative divisor are leading zeros of its inverse
  assign lead_src = b_neg ? ~req.op_b : req.op_b;

  // highest set bit wins, all zero gives XLEN
  always_comb begin
    lead_cnt = LOG_XLEN'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (lead_src[i]) begin
        lead_cnt = LOG_XLEN'(XLEN - 1 - i);
      end
    end
  end

  // keep one sign bit on negative divisors
  // so the magnitude still fits after shifting
  assign shift = lead_cnt - LOG_XLEN'(b_neg);

  always_comb begin
    div_req.op_a         = req.op_a;
    div_req.op_b         = req.op_b << shift;
    div_req.op_b_shift   = shift;
    div_req.op_b_is_zero = (req.op_b == '0);
    div_req.op_b_sign    = b_neg;
    div_req.div_signed   = div_signed;
    div_req.div_rem      = div_rem;
  end

  always_comb begin
    mul_req.op_a     = req.op_a;
    mul_req.op_b     = req.op_b;
    mul_req.a_signed = a_signed;
    mul_req.b_signed = b_signed;
    mul_req.high     = high;
  end

endmodule

// ==== logic/md_serial_div.sv ====
////////////////////////////////////////////////////////////////////////////
// serial restoring divider producing one quotient bit per cycle
// a one-cycle start pulse loads it and the result is held until out_rdy
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module md_serial_div import md_pkg::*; (
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  input  logic            start,
  input  div_req_t        req,
  input  logic            out_rdy,
  output logic            out_vld,
  output logic [XLEN-1:0] res
);

  div_state_e          state_d, state_q;
  logic [LOG_XLEN-1:0] cnt_d, cnt_q;
  logic                cnt_zero;

  // remainder, shifting divisor, reversed quotient
  logic [XLEN-1:0]     a_d, a_q;
  logic [XLEN-1:0]     b_d, b_q;
  logic [XLEN-1:0]     res_d, res_q;
  logic [XLEN-1:0]     res_rev;

  logic                rem_sel_q;
  logic                res_inv_q;

  logic                load;
  logic                step;
  logic                ge;
  logic                a_neg;
  logic [XLEN-1:0]     b_mag;
  logic [XLEN-1:0]     add_x;
  logic [XLEN-1:0]     add_y;
  logic                add_sub;
  logic [XLEN-1:0]     add_out;
  logic [XLEN-1:0]     out_mux;

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  assign a_neg = req.div_signed & req.op_a[XLEN-1];
  // divisor sign is already gated for unsigned ops
  assign b_mag = req.op_b_sign ? -req.op_b : req.op_b;

  // shared adder
  // load takes 0 +/- dividend
  // divide takes remainder minus divisor
  assign add_x   = load ? '0 : a_q;
  assign add_y   = load ? req.op_a : b_q;
  assign add_sub = load ? a_neg : 1'b1;
  assign add_out = add_sub ? add_x - add_y : add_x + add_y;

  // quotient bit
  assign ge = (a_q >= b_q);

  // quotient bits enter at the top with the msb first
  assign res_rev = {<<{res_q}};
  assign out_mux = rem_sel_q ? a_q : res_rev;
  assign res     = res_inv_q ? -out_mux : out_mux;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////

  assign cnt_zero = (cnt_q == '0);

  always_comb begin
    state_d = state_q;
    out_vld = 1'b0;
    load    = 1'b0;
    step    = 1'b0;
    case (state_q)
      DIV_IDLE: begin
        // idle reports valid until a start arrives
        out_vld = ~start;
        if (start) begin
          load    = 1'b1;
          state_d = DIV_DIVIDE;
        end
      end
      DIV_DIVIDE: begin
        step = 1'b1;
        // last compare happens at count zero
        if (cnt_zero) begin
          state_d = DIV_FINISH;
        end
      end
      DIV_FINISH: begin
        out_vld = 1'b1;
        if (out_rdy) begin
          state_d = DIV_IDLE;
        end
      end
      default: state_d = DIV_IDLE;
    endcase
  end

  assign cnt_d = load                ? req.op_b_shift :
                 (step & ~cnt_zero)  ? cnt_q - 1'b1   : cnt_q;

  // remainder only updates when the divisor fits
  assign a_d   = (load | (step & ge)) ? add_out : a_q;
  assign b_d   = load ? b_mag : step ? (b_q >> 1) : b_q;
  assign res_d = load ? '0 : step ? {ge, res_q[XLEN-1:1]} : res_q;

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      state_q   <= DIV_IDLE;
      cnt_q     <= '0;
      rem_sel_q <= 1'b0;
      res_inv_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (load) begin
        rem_sel_q <= req.div_rem;
        // remainder follows the dividend sign
        // quotient of a zero divisor stays all ones
        res_inv_q <= req.div_rem ? a_neg :
                     (a_neg ^ req.op_b_sign) & ~req.op_b_is_zero;
      end
    end
  end

  always_ff @(posedge Clk_CI) begin
    a_q   <= a_d;
    b_q   <= b_d;
    res_q <= res_d;
  end

endmodule

// ==== logic/md_serial_mul.sv ====
////////////////////////////////////////////////////////////////////////////
// serial shift-add multiplier on magnitudes, XLEN cycles per product
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module md_serial_mul import md_pkg::*; (
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  input  logic            start,
  input  mul_req_t        req,
  input  logic            out_rdy,
  output logic            out_vld,
  output logic [XLEN-1:0] res
);

  mul_state_e          state_d, state_q;
  logic [LOG_XLEN-1:0] cnt_q;
  logic                cnt_zero;
  logic                neg_q;
  logic                high_q;

  logic [XLEN-1:0]     mcand_q;
  // upper half accumulates, lower half holds the remaining multiplier bits
  logic [2*XLEN-1:0]   prod_q;

  logic                load;
  logic                step;
  logic                a_neg;
  logic                b_neg;
  logic [XLEN-1:0]     a_mag;
  logic [XLEN-1:0]     b_mag;
  logic [XLEN-1:0]     addend;
  logic [XLEN:0]       sum;
  logic [2*XLEN-1:0]   prod_fin;

  // operand magnitudes
  assign a_neg = req.a_signed & req.op_a[XLEN-1];
  assign b_neg = req.b_signed & req.op_b[XLEN-1];
  assign a_mag = a_neg ? -req.op_a : req.op_a;
  assign b_mag = b_neg ? -req.op_b : req.op_b;

  // add multiplicand when the low multiplier bit is set
  assign addend = prod_q[0] ? mcand_q : '0;
  assign sum    = {1'b0, prod_q[2*XLEN-1:XLEN]} + {1'b0, addend};

  // sign fixup over the full double word
  assign prod_fin = neg_q ? -prod_q : prod_q;
  assign res      = high_q ? prod_fin[2*XLEN-1:XLEN] : prod_fin[XLEN-1:0];

  assign cnt_zero = (cnt_q == '0);

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    out_vld = 1'b0;
    load    = 1'b0;
    step    = 1'b0;
    case (state_q)
      MUL_IDLE: begin
        if (start) begin
          load    = 1'b1;
          state_d = MUL_RUN;
        end
      end
      MUL_RUN: begin
        step = 1'b1;
        if (cnt_zero) begin
          state_d = MUL_FINISH;
        end
      end
      MUL_FINISH: begin
        out_vld = 1'b1;
        if (out_rdy) begin
          state_d = MUL_IDLE;
        end
      end
      default: state_d = MUL_IDLE;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
      neg_q   <= 1'b0;
      high_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load) begin
        // XLEN run cycles, counting down to zero
        cnt_q  <= LOG_XLEN'(XLEN - 1);
        neg_q  <= a_neg ^ b_neg;
        high_q <= req.high;
      end else if (step & ~cnt_zero) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge Clk_CI) begin
    if (load) begin
      mcand_q <= a_mag;
      prod_q  <= {{XLEN{1'b0}}, b_mag};
    end else if (step) begin
      // carry moves into the top bit as everything shifts right
      prod_q <= {sum, prod_q[XLEN-1:1]};
    end
  end

endmodule

// ==== logic/md_result_sel.sv ====
////////////////////////////////////////////////////////////////////////////
// accept/busy tracking, unit start and output selection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module md_result_sel import md_pkg::*; (
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  input  logic            in_vld,
  input  logic            is_div,
  input  logic            out_rdy,
  input  logic            div_vld,
  input  logic            mul_vld,
  input  logic [XLEN-1:0] div_res,
  input  logic [XLEN-1:0] mul_res,
  output logic            in_rdy,
  output logic            div_start,
  output logic            mul_start,
  output logic            div_out_rdy,
  output logic            mul_out_rdy,
  output logic            out_vld,
  output logic [XLEN-1:0] result
);

  logic busy_q;
  logic owner_div_q;
  logic accept;
  logic done;

  // one operation in flight
  assign in_rdy = ~busy_q;
  assign accept = in_vld & in_rdy;

  // start pulses go to the unit that owns the new op
  assign div_start = accept & is_div;
  assign mul_start = accept & ~is_div;

  // busy only rises on the start edge, so it also masks
  // the divider valid that idle reports before the start
  assign out_vld = busy_q & (owner_div_q ? div_vld : mul_vld);
  assign result  = owner_div_q ? div_res : mul_res;

  // ready only reaches the owner
  assign div_out_rdy = busy_q & owner_div_q & out_rdy;
  assign mul_out_rdy = busy_q & ~owner_div_q & out_rdy;

  assign done = out_vld & out_rdy;

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      busy_q      <= 1'b0;
      owner_div_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q      <= 1'b1;
        owner_div_q <= is_div;
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/md_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// RISC-V M-extension multiply/divide unit, one operation at a time
// in_vld/in_rdy accept a request, out_vld/out_rdy hand back the result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module md_unit import md_pkg::*; (
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  input  logic            in_vld,
  input  md_req_t         req,
  input  logic            out_rdy,
  output logic            in_rdy,
  output logic            out_vld,
  output logic [XLEN-1:0] result
);

  div_req_t        div_req;
  mul_req_t        mul_req;
  logic            is_div;
  logic            div_start;
  logic            mul_start;
  logic            div_out_rdy;
  logic            mul_out_rdy;
  logic            div_vld;
  logic            mul_vld;
  logic [XLEN-1:0] div_res;
  logic [XLEN-1:0] mul_res;

  // operand preparation
  md_op_decode i_op_decode (
    .req     (req),
    .div_req (div_req),
    .mul_req (mul_req),
    .is_div  (is_div)
  );

  // execution units side by side
  md_serial_div i_serial_div (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .start   (div_start),
    .req     (div_req),
    .out_rdy (div_out_rdy),
    .out_vld (div_vld),
    .res     (div_res)
  );

  md_serial_mul i_serial_mul (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .start   (mul_start),
    .req     (mul_req),
    .out_rdy (mul_out_rdy),
    .out_vld (mul_vld),
    .res     (mul_res)
  );

  // handshake and result mux
  md_result_sel i_result_sel (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .in_vld      (in_vld),
    .is_div      (is_div),
    .out_rdy     (out_rdy),
    .div_vld     (div_vld),
    .mul_vld     (mul_vld),
    .div_res     (div_res),
    .mul_res     (mul_res),
    .in_rdy      (in_rdy),
    .div_start   (div_start),
    .mul_start   (mul_start),
    .div_out_rdy (div_out_rdy),
    .mul_out_rdy (mul_out_rdy),
    .out_vld     (out_vld),
    .result      (result)
  );

endmodule

// ==== include/md_ref_model.svh ====
////////////////////////////////////////////////////////////////////////////
// expected results of all eight operations for the testbench
// include inside a scope that already imports md_pkg
////////////////////////////////////////////////////////////////////////////

`ifndef MD_REF_MODEL_SVH
`define MD_REF_MODEL_SVH

function automatic logic [XLEN-1:0] md_ref_result(
  input md_op_e          op,
  input logic [XLEN-1:0] op_a,
  input logic [XLEN-1:0] op_b
);
  logic signed [XLEN-1:0] sa;
  logic signed [XLEN-1:0] sb;
  logic [2*XLEN-1:0]      ext_a;
  logic [2*XLEN-1:0]      ext_b;
  logic [2*XLEN-1:0]      prod;
  logic                   ovf;

  sa = op_a;
  sb = op_b;
  // sign extension per operand, product taken modulo 2^(2*XLEN)
  ext_a = (op == MULH || op == MULHSU) ? {{XLEN{op_a[XLEN-1]}}, op_a} : {{XLEN{1'b0}}, op_a};
  ext_b = (op == MULH) ? {{XLEN{op_b[XLEN-1]}}, op_b} : {{XLEN{1'b0}}, op_b};
  prod  = ext_a * ext_b;
  // most negative value divided by minus one
  ovf   = (op_a == {1'b1, {(XLEN-1){1'b0}}}) && (op_b == '1);

  case (op)
    MUL:    return prod[XLEN-1:0];
    MULH:   return prod[2*XLEN-1:XLEN];
    MULHSU: return prod[2*XLEN-1:XLEN];
    MULHU:  return prod[2*XLEN-1:XLEN];
    DIV:    return (op_b == '0) ? '1 : ovf ? op_a : XLEN'(sa / sb);
    DIVU:   return (op_b == '0) ? '1 : op_a / op_b;
    REM:    return (op_b == '0) ? op_a : ovf ? '0 : XLEN'(sa % sb);
    REMU:   return (op_b == '0) ? op_a : op_a % op_b;
    default: return '0;
  endcase
endfunction

`endif

// ==== bench/tb_md_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench of the multiply/divide unit, random and corner operations
// checked against the reference model, with random output back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_md_unit import md_pkg::*; ();

  `include "md_ref_model.svh"

  // cycles any single wait may take
  localparam int TIMEOUT = 100;
  // operations per random section
  localparam int N_RAND  = 200;

  logic            Clk_CI;
  logic            Rst_RBI;
  logic            in_vld;
  md_req_t         req;
  logic            out_rdy;
  logic            in_rdy;
  logic            out_vld;
  logic [XLEN-1:0] result;
  integer          seed;

  md_unit i_dut (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .in_vld  (in_vld),
    .req     (req),
    .out_rdy (out_rdy),
    .in_rdy  (in_rdy),
    .out_vld (out_vld),
    .result  (result)
  );

  // 100 ns period
  always #50 Clk_CI = ~Clk_CI;

  ////////////////////////////////////////////////////////////////////////////
  // checks and random helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    assert (act === exp) else begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  function automatic logic [XLEN-1:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // mix of small, negative and oversized divisors
  task automatic make_div_operands(output logic [XLEN-1:0] a, output logic [XLEN-1:0] b);
    a = rand_word();
    case (rand_below(4))
      // small, zero included
      0: b = XLEN'(rand_below(16));
      // small negative
      1: b = -XLEN'(rand_below(16) + 1);
      // divisor above the dividend
      2: begin
        b = rand_word();
        a = b >> (rand_below(8) + 1);
      end
      default: b = rand_word();
    endcase
  endtask

  task automatic wait_for_in_rdy();
    int n;
    n = 0;
    while (!in_rdy && n < TIMEOUT) begin
      @(negedge Clk_CI);
      n++;
    end
    assert (in_rdy) else begin
      $display("timeout at %0t: in_rdy stayed low for %0d cycles", $time, TIMEOUT);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one full operation, accept to output handshake
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_op(input md_op_e op, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b);
    logic [XLEN-1:0] expected;
    logic [XLEN-1:0] held;
    int              stall;
    int              n;
    expected = md_ref_result(op, a, b);
    wait_for_in_rdy();
    req.op   = op;
    req.op_a = a;
    req.op_b = b;
    in_vld   = 1'b1;
    @(negedge Clk_CI);
    in_vld   = 1'b0;
    // operands latched at the accept edge, scramble the request
    req.op   = md_op_e'(rand_below(8));
    req.op_a = rand_word();
    req.op_b = rand_word();
    n = 0;
    while (!out_vld && n < TIMEOUT) begin
      check_bit("in_rdy", 1'b0, in_rdy);
      @(negedge Clk_CI);
      n++;
    end
    assert (out_vld) else begin
      $display("timeout at %0t: out_vld never rose for op %s", $time, op.name());
      $display("tests failed");
      $fatal(1);
    end
    check_value("result", expected, result);
    // hold the output back for a few cycles
    held  = result;
    stall = rand_below(6);
    repeat (stall) begin
      @(negedge Clk_CI);
      check_bit("out_vld", 1'b1, out_vld);
      check_value("result", held, result);
      check_bit("in_rdy", 1'b0, in_rdy);
    end
    out_rdy = 1'b1;
    @(negedge Clk_CI);
    out_rdy = 1'b0;
    // handshake done, unit free again
    check_bit("out_vld", 1'b0, out_vld);
    check_bit("in_rdy", 1'b1, in_rdy);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] corner [5];
    seed    = 69;
    Clk_CI  = 1'b0;
    Rst_RBI = 1'b0;
    in_vld  = 1'b0;
    out_rdy = 1'b0;
    req     = '0;
    repeat (8) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);
    // idle after reset
    check_bit("in_rdy", 1'b1, in_rdy);
    check_bit("out_vld", 1'b0, out_vld);

    // random multiplies
    for (int i = 0; i < N_RAND; i++) begin
      run_op(md_op_e'(rand_below(4)), rand_word(), rand_word());
    end

    // random divides
    for (int i = 0; i < N_RAND; i++) begin
      make_div_operands(a, b);
      run_op(md_op_e'(4 + rand_below(4)), a, b);
    end

    // zero divisor, overflow, zero and minus one on every op
    corner = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff};
    for (int o = 0; o < 8; o++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_op(md_op_e'(o), corner[i], corner[j]);
        end
      end
    end

    // alternate units back to back
    for (int i = 0; i < N_RAND; i++) begin
      if (i % 2 == 0) begin
        run_op(md_op_e'(rand_below(4)), rand_word(), rand_word());
      end else begin
        make_div_operands(a, b);
        run_op(md_op_e'(4 + rand_below(4)), a, b);
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
logic/md_pkg.sv
logic/md_op_decode.sv
logic/md_serial_div.sv
logic/md_serial_mul.sv
logic/md_result_sel.sv
logic/md_unit.sv
bench/tb_md_unit.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_md_unit -o tb_md_unit
	out=$$(./obj_dir/tb_md_unit); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
